// ==== design/ctrlPkg.sv ====
package ctrlPkg;

	// Microstate and instruction word
	localparam int StateW = 10;

	typedef logic [StateW-1:0] stateT;
	typedef logic [31:0]       irT;

	// Fetch loop
	localparam stateT StReset     = 10'd0;
	localparam stateT StFetch0    = 10'd1;	// Start of every instruction
	localparam stateT StFetch1    = 10'd2;
	localparam stateT StFetchWait = 10'd3;	// Waits on instruction memory
	localparam stateT StDecode    = 10'd4;	// Dispatch point

	// Data-processing entry states
	localparam stateT StDpReg  = 10'd5;
	localparam stateT StDpImm  = 10'd6;
	localparam stateT StDpRegS = 10'd7;	// Flag-setting forms
	localparam stateT StDpImmS = 10'd8;
	localparam stateT StCmpReg = 10'd9;	// Compare forms
	localparam stateT StCmpImm = 10'd10;

	// Load/store block bases, one four-state block per form
	localparam stateT LdImmBase = 10'd11;
	localparam stateT LdRegBase = 10'd15;
	localparam stateT StImmBase = 10'd59;
	localparam stateT StRegBase = 10'd63;

	// Added to the base for each addressing variant
	localparam stateT PreOffset  = 10'd8;
	localparam stateT PostOffset = 10'd16;
	localparam stateT ByteOffset = 10'd24;
	localparam stateT SubOffset  = 10'd96;	// Whole second half of the range

	// Load/store state space
	localparam stateT LsFirst = 10'd11;
	localparam stateT LsLast  = 10'd202;

	// Stores sit in two windows, loads fill the rest of LsFirst..LsLast
	localparam stateT StFirstAdd = 10'd59;
	localparam stateT StLastAdd  = 10'd106;
	localparam stateT StFirstSub = 10'd155;
	localparam stateT StLastSub  = 10'd202;

	// Branch states
	localparam stateT StBranch     = 10'd459;
	localparam stateT StBranchLink = 10'd460;

	// Class codes in ir[27:25]
	localparam logic [2:0] ClsDpReg  = 3'b000;
	localparam logic [2:0] ClsDpImm  = 3'b001;
	localparam logic [2:0] ClsLsImm  = 3'b010;
	localparam logic [2:0] ClsLsReg  = 3'b011;
	localparam logic [2:0] ClsBranch = 3'b101;

	// Field positions
	localparam int ClassHi  = 27;
	localparam int ClassLo  = 25;
	localparam int BitReg   = 25;	// Register offset in load/store class
	localparam int OpcodeHi = 24;
	localparam int OpcodeLo = 21;
	localparam int BitP = 24;	// Pre-index, also link bit of branch
	localparam int BitU = 23;
	localparam int BitB = 22;
	localparam int BitW = 21;
	localparam int BitL = 20;
	localparam int BitS = 20;	// Same bit as L, other class
	localparam int Bit7 = 7;
	localparam int Bit4 = 4;

	// Compare opcodes (TST, TEQ)
	localparam logic [3:0] CmpOpLo = 4'b1000;
	localparam logic [3:0] CmpOpHi = 4'b1001;

endpackage

// ==== design/lsEntryEncoder.sv ====
`timescale 1ns/10ps

module lsEntryEncoder (
	input  ctrlPkg::irT    ir,
	output ctrlPkg::stateT lsEntry
);

	import ctrlPkg::*;

	stateT base;
	stateT preAdd;
	stateT postAdd;
	stateT byteAdd;
	stateT subAdd;

	logic preIdx;
	logic postIdx;

	// Pick the block family
	always_comb begin
		if (ir[BitL]) begin
			base = ir[BitReg] ? LdRegBase : LdImmBase;	// Loads
		end else begin
			base = ir[BitReg] ? StRegBase : StImmBase;	// Stores
		end
	end

	// P with W is pre-index, P clear is post-index, P alone is offset
	assign preIdx  = ir[BitP] & ir[BitW];
	assign postIdx = ~ir[BitP];

	assign preAdd  = preIdx ? PreOffset : '0;
	assign postAdd = postIdx ? PostOffset : '0;
	assign byteAdd = ir[BitB] ? ByteOffset : '0;
	assign subAdd  = ir[BitU] ? '0 : SubOffset;	// U clear subtracts the offset

	// The offsets never overlap, so the sum stays inside LsFirst..LsLast
	assign lsEntry = base + preAdd + postAdd + byteAdd + subAdd;

endmodule

// ==== design/instrClassifier.sv ====
`timescale 1ns/10ps

module instrClassifier (
	input  ctrlPkg::irT    ir,
	input  logic           cond,
	output ctrlPkg::stateT dispatchState
);

	import ctrlPkg::*;

	logic [2:0] instrClass;
	logic [3:0] opcode;

	logic isDpReg;
	logic isDpImm;
	logic isLs;
	logic isBranch;
	logic isCmp;

	stateT lsEntry;

	lsEntryEncoder u_lsEntryEncoder (
		.ir      (ir),
		.lsEntry (lsEntry)
	);

	assign instrClass = ir[ClassHi:ClassLo];
	assign opcode     = ir[OpcodeHi:OpcodeLo];

	// Bits 7 and 4 both set mark the extra load/store forms, not handled here
	assign isDpReg = (instrClass == ClsDpReg) & ~(ir[Bit7] & ir[Bit4]);
	assign isDpImm = (instrClass == ClsDpImm);

	// Register offset with bit 4 set is the media space
	assign isLs = (instrClass == ClsLsImm) |
	              ((instrClass == ClsLsReg) & ~ir[Bit4]);

	assign isBranch = (instrClass == ClsBranch);

	assign isCmp = (opcode == CmpOpLo) | (opcode == CmpOpHi);

	always_comb begin
		dispatchState = StFetch0;	// Unknown and skipped instructions
		if (cond) begin
			if (isDpReg) begin
				if (isCmp) begin
					dispatchState = StCmpReg;
				end else if (ir[BitS]) begin
					dispatchState = StDpRegS;
				end else begin
					dispatchState = StDpReg;
				end
			end else if (isDpImm) begin
				if (isCmp) begin
					dispatchState = StCmpImm;
				end else if (ir[BitS]) begin
					dispatchState = StDpImmS;
				end else begin
					dispatchState = StDpImm;
				end
			end else if (isLs) begin
				dispatchState = lsEntry;
			end else if (isBranch) begin
				dispatchState = ir[BitP] ? StBranchLink : StBranch;	// Link bit
			end
		end
	end

endmodule

// ==== design/stateSequencer.sv ====
`timescale 1ns/10ps

module stateSequencer (
	input  logic           clk,
	input  logic           rst,
	input  ctrlPkg::stateT dispatchState,
	input  logic           moc,
	output ctrlPkg::stateT state,
	output logic           memReq
);

	import ctrlPkg::*;

	stateT nextState;
	stateT lsOffset;

	logic [1:0] blockPos;
	logic inLs;
	logic isStore;
	logic waitPos;
	logic isWait;
	logic memDone;
	logic memReqNext;

	// Block membership and position come straight from the state number
	assign inLs     = (state >= LsFirst) & (state <= LsLast);
	assign isStore  = ((state >= StFirstAdd) & (state <= StLastAdd)) |
	                  ((state >= StFirstSub) & (state <= StLastSub));
	assign lsOffset = state - LsFirst;
	assign blockPos = lsOffset[1:0];	// Blocks are four states, aligned to LsFirst

	// Loads wait on the third state, stores on the fourth
	assign waitPos = isStore ? (blockPos == 2'd3) : (blockPos == 2'd2);
	assign isWait  = (state == StFetchWait) | (inLs & waitPos);

	// Completion edge of the four-phase handshake
	assign memDone = memReq & moc;

	// Request only while moc is low, so a stale acknowledge must clear first.
	// When memDone is seen the state leaves the wait state and the request drops.
	assign memReqNext = isWait & ~moc;

	always_comb begin
		nextState = StFetch0;	// Single-cycle execution states
		case (state)
			StReset: nextState = StFetch0;
			StFetch0: nextState = StFetch1;
			StFetch1: nextState = StFetchWait;
			StFetchWait: begin
				nextState = memDone ? StDecode : StFetchWait;	// Hold is back-pressure
			end
			StDecode: nextState = dispatchState;
			default: begin
				if (inLs) begin
					if (isWait & ~memDone) begin
						nextState = state;	// Memory not done yet
					end else if (blockPos == 2'd3) begin
						nextState = StFetch0;	// End of block
					end else begin
						nextState = state + 1'b1;
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= StReset;
			memReq <= 1'b0;
		end else begin
			state  <= nextState;
			memReq <= memReqNext;
		end
	end

endmodule

// ==== design/armControlUnit.sv ====
`timescale 1ns/10ps

module armControlUnit (
	input  logic           clk,
	input  logic           rst,
	input  ctrlPkg::irT    ir,
	input  logic           cond,	// Condition-pass flag
	input  logic           moc,	// Memory acknowledge
	output ctrlPkg::stateT state,
	output logic           memReq
);

	import ctrlPkg::*;

	stateT dispatchState;	// Only sampled in StDecode

	instrClassifier u_instrClassifier (
		.ir            (ir),
		.cond          (cond),
		.dispatchState (dispatchState)
	);

	stateSequencer u_stateSequencer (
		.clk           (clk),
		.rst           (rst),
		.dispatchState (dispatchState),
		.moc           (moc),
		.state         (state),
		.memReq        (memReq)
	);

endmodule

// ==== testbench/armControlUnit_props.sv ====
`timescale 1ns/10ps

module armControlUnit_props (
	input logic           clk,
	input logic           rst,
	input logic           moc,
	input ctrlPkg::stateT state,
	input logic           memReq
);

	import ctrlPkg::*;

	int failCount = 0;	// Failed assertions so far

	stateT lsOffset;
	logic [1:0] pos;
	logic inLs;
	logic inStore;
	logic waitHere;
	logic done;
	logic singleCycle;

	assign inLs     = state inside {[LsFirst:LsLast]};
	assign inStore  = state inside {[StFirstAdd:StLastAdd], [StFirstSub:StLastSub]};
	assign lsOffset = state - LsFirst;
	assign pos      = lsOffset[1:0];	// Position inside a four-state block

	// Loads wait at position 2, stores at position 3
	assign waitHere = (state == StFetchWait) || (inLs && pos == (inStore ? 2'd3 : 2'd2));
	assign done     = memReq && moc;

	assign singleCycle = state inside {[StDpReg:StCmpImm], StBranch, StBranchLink};

	assert property (@(posedge clk) rst |=> (state == StReset && !memReq))
	else begin
		failCount++;
		$error("state or memReq not cleared by reset");
	end

	// Fetch steps right after reset release
	assert property (@(posedge clk) $fell(rst) |-> state == StReset ##1 state == StFetch0
		##1 state == StFetch1 ##1 state == StFetchWait)
	else begin
		failCount++;
		$error("fetch sequence after reset is wrong");
	end

	assert property (@(posedge clk) disable iff (rst)
		state == StFetch0 |=> state == StFetch1 ##1 state == StFetchWait)
	else begin
		failCount++;
		$error("fetch steps did not follow one per cycle");
	end

	assert property (@(posedge clk) disable iff (rst) $rose(memReq) |-> !$past(moc))
	else begin
		failCount++;
		$error("memReq rose while moc was still high");
	end

	// Request holds until moc is seen, then drops on that edge
	assert property (@(posedge clk) disable iff (rst) memReq |=> memReq == !$past(moc))
	else begin
		failCount++;
		$error("memReq did not follow the four-phase handshake");
	end

	assert property (@(posedge clk) disable iff (rst) memReq |-> waitHere)
	else begin
		failCount++;
		$error("memReq high outside a wait state");
	end

	assert property (@(posedge clk) disable iff (rst)
		waitHere && !done |=> state == $past(state))
	else begin
		failCount++;
		$error("state left a wait state before the handshake completed");
	end

	assert property (@(posedge clk) disable iff (rst)
		state == StFetchWait && done |=> state == StDecode)
	else begin
		failCount++;
		$error("fetch wait did not go to decode on completion");
	end

	assert property (@(posedge clk) disable iff (rst) inLs && !(waitHere && !done)
		|=> state == (($past(pos) == 2'd3) ? StFetch0 : $past(state) + 1'b1))
	else begin
		failCount++;
		$error("load/store block walk is wrong");
	end

	assert property (@(posedge clk) disable iff (rst) singleCycle |=> state == StFetch0)
	else begin
		failCount++;
		$error("single-cycle state did not return to fetch");
	end

endmodule

bind armControlUnit armControlUnit_props u_props (
	.clk    (clk),
	.rst    (rst),
	.moc    (moc),
	.state  (state),
	.memReq (memReq)
);

// ==== testbench/tb_armControlUnit.sv ====
`timescale 1ns/10ps

module tb_armControlUnit;

	import ctrlPkg::*;

	localparam int ClkPeriod      = 8;
	localparam int CyclesPerInstr = 40;	// Fetch, decode and worst block with slow memory
	localparam int NumInstr       = 4 + 18 + 10 + 64 + 4;

	logic  clk;
	logic  rst;
	irT    ir;
	logic  cond;
	logic  moc;
	stateT state;
	logic  memReq;

	integer seed = 77109;
	int errCount = 0;
	int checkCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int testErrStart;
	int testCheckStart;

	armControlUnit u_armControlUnit (
		.clk    (clk),
		.rst    (rst),
		.ir     (ir),
		.cond   (cond),
		.moc    (moc),
		.state  (state),
		.memReq (memReq)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic int totalErrors();
		return errCount + u_armControlUnit.u_props.failCount;
	endfunction

	// Entry state of a load/store block
	function automatic stateT expectLsEntry(input irT i);
		stateT e;
		case ({i[BitL], i[BitReg]})
			2'b10: e = LdImmBase;
			2'b11: e = LdRegBase;
			2'b00: e = StImmBase;
			default: e = StRegBase;
		endcase
		if (i[BitP] && i[BitW])
			e = e + PreOffset;
		if (!i[BitP])
			e = e + PostOffset;
		if (i[BitB])
			e = e + ByteOffset;
		if (!i[BitU])
			e = e + SubOffset;
		return e;
	endfunction

	function automatic stateT expectTarget(input irT i, input logic c);
		logic [2:0] cls;
		logic cmp;
		stateT t;
		cls = i[ClassHi:ClassLo];
		cmp = (i[OpcodeHi:OpcodeLo] == CmpOpLo) || (i[OpcodeHi:OpcodeLo] == CmpOpHi);
		t = StFetch0;	// Skipped or unknown
		if (c) begin
			if (cls == ClsDpReg && !(i[Bit7] && i[Bit4]))
				t = cmp ? StCmpReg : (i[BitS] ? StDpRegS : StDpReg);
			else if (cls == ClsDpImm)
				t = cmp ? StCmpImm : (i[BitS] ? StDpImmS : StDpImm);
			else if (cls == ClsLsImm || (cls == ClsLsReg && !i[Bit4]))
				t = expectLsEntry(i);
			else if (cls == ClsBranch)
				t = i[BitP] ? StBranchLink : StBranch;
		end
		return t;
	endfunction

	function automatic irT randomInstr(input logic [2:0] cls);
		irT i;
		i = $random(seed);
		i[ClassHi:ClassLo] = cls;
		return i;
	endfunction

	// kind 0 plain, 1 flag-setting, 2 compare
	function automatic irT makeDp(input logic imm, input int kind);
		irT i;
		i = randomInstr(imm ? ClsDpImm : ClsDpReg);
		if (!imm)
			i[Bit4] = 1'b0;	// Stay out of the extra load/store space
		if (kind == 2) begin
			i[OpcodeHi:OpcodeLo] = i[0] ? CmpOpHi : CmpOpLo;
		end else begin
			if (i[OpcodeHi:OpcodeLo] inside {CmpOpLo, CmpOpHi})
				i[OpcodeLo + 1] = 1'b1;	// Move off the compare opcodes
			i[BitS] = (kind == 1);
		end
		return i;
	endfunction

	task automatic checkValue(input string sigName, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		assert (actual === expected)
		else begin
			errCount++;
			$display("MISMATCH %s: expected %h, got %h", sigName, expected, actual);
		end
	endtask

	// Drive one instruction at decode and check the dispatch one cycle later
	task automatic issue(input irT instr, input logic c);
		stateT expected;
		expected = expectTarget(instr, c);
		while (state !== StDecode)
			@(negedge clk);
		ir = instr;
		cond = c;
		@(negedge clk);
		checkValue("state", expected, state);
	endtask

	task automatic startTest();
		testErrStart = totalErrors();
		testCheckStart = checkCount;
	endtask

	task automatic endTest(input string name);
		int errs;
		errs = totalErrors() - testErrStart;
		if (errs == 0) begin
			testsPassed++;
			$display("PASS %s (%0d checks)", name, checkCount - testCheckStart);
		end else begin
			testsFailed++;
			$display("FAIL %s (%0d errors)", name, errs);
		end
	endtask

	// Memory side of the four-phase handshake
	initial begin : memResponder
		int delay;
		moc = 1'b0;
		forever begin
			@(negedge clk);
			if (memReq && !moc) begin
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay - 1)
					@(negedge clk);
				moc = 1'b1;
				while (memReq)
					@(negedge clk);
				delay = 1 + ($unsigned($random(seed)) % 3);
				repeat (delay - 1)
					@(negedge clk);
				moc = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(NumInstr * CyclesPerInstr * ClkPeriod);
		$display("Timeout: the run did not finish within %0d cycles",
			NumInstr * CyclesPerInstr);
		$display("Simulation failed");
		$finish;
	end

	initial begin : mainSeq
		irT i;
		clk = 1'b0;
		rst = 1'b1;
		ir = '0;
		cond = 1'b0;

		startTest();
		repeat (2) begin
			@(negedge clk);
			checkValue("state", StReset, state);
			checkValue("memReq", 1'b0, memReq);
		end
		rst = 1'b0;
		endTest("reset");

		startTest();
		repeat (4)
			issue(randomInstr(3'($random(seed))), 1'b0);
		endTest("condition skip");

		startTest();
		for (int k = 0; k < 6; k++) begin
			repeat (3)
				issue(makeDp(k[0], k / 2), 1'b1);
		end
		endTest("data-processing dispatch");

		startTest();
		repeat (2) begin
			i = randomInstr(ClsDpReg);
			i[Bit7] = 1'b1;	// Extra load/store forms
			i[Bit4] = 1'b1;
			issue(i, 1'b1);
			issue(randomInstr(3'b100), 1'b1);	// Load/store multiple
			i = randomInstr(ClsLsReg);
			i[Bit4] = 1'b1;
			issue(i, 1'b1);
			issue(randomInstr(3'b110), 1'b1);
			issue(randomInstr(3'b111), 1'b1);
		end
		endTest("unknown instructions");

		startTest();
		for (int n = 0; n < 64; n++) begin
			i = randomInstr(n[5] ? ClsLsReg : ClsLsImm);
			i[BitL] = n[4];
			i[BitP] = n[3];
			i[BitW] = n[2];
			i[BitB] = n[1];
			i[BitU] = n[0];
			i[Bit4] = 1'b0;	// Register offset needs bit 4 clear
			issue(i, 1'b1);
		end
		endTest("load/store entry and walk");

		startTest();
		for (int n = 0; n < 4; n++) begin
			i = randomInstr(ClsBranch);
			i[BitP] = n[0];
			issue(i, 1'b1);
		end
		while (state !== StFetch0)
			@(negedge clk);
		@(negedge clk);	// One more edge so the last return to fetch is sampled
		endTest("branch");

		$display("Tests: %0d passed, %0d failed, %0d checks, %0d errors",
			testsPassed, testsFailed, checkCount, totalErrors());
		if (testsFailed == 0 && totalErrors() == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
design/ctrlPkg.sv
design/lsEntryEncoder.sv
design/instrClassifier.sv
design/stateSequencer.sv
design/armControlUnit.sv
testbench/armControlUnit_props.sv
testbench/tb_armControlUnit.sv

// ==== Bender.yml ====
package:
  name: arm_control_unit

sources:
  - files:
      - design/ctrlPkg.sv
      - design/lsEntryEncoder.sv
      - design/instrClassifier.sv
      - design/stateSequencer.sv
      - design/armControlUnit.sv
  - target: test
    files:
      - testbench/armControlUnit_props.sv
      - testbench/tb_armControlUnit.sv
